//--- run_sim.sh
#!/bin/sh
# Build and run the packet FIFO testbench with Verilator, from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pkt_fifo_async -f tb.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi
if ! grep -q "All tests passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

//--- src/axis_if.sv
// axis_if: one stream beat with valid/ready handshake, last and error flag
`timescale 1ns/1ps

interface axis_if;

   // handshake pair
   logic            tvalid;
   logic            tready;

   // beat payload
   axis_pkg::data_t tdata;
   axis_pkg::keep_t tkeep;
   // end of packet
   logic            tlast;
   // error flag, meaningful on the last beat
   logic            tuser;

   // sender side drives everything but tready
   modport tx (
      output tvalid, tdata, tkeep, tlast, tuser,
      input  tready
   );

   // receiver side only answers with tready
   modport rx (
      input  tvalid, tdata, tkeep, tlast, tuser,
      output tready
   );

endinterface

//--- src/axis_pkg.sv
// axis_pkg: stream-side widths and beat types shared by the packet FIFO
package axis_pkg;

   // --------------------------------------------------------------------------
   // beat geometry
   // --------------------------------------------------------------------------

   // payload bits per beat
   localparam int data_width = 32;
   // one keep flag per payload byte
   localparam int keep_width = data_width / 8;
   // stored word holds data, keep and last (tuser never reaches memory)
   localparam int beat_width = data_width + keep_width + 1;

   // field positions inside a stored beat, laid out as {last, keep, data}
   localparam int keep_lsb = data_width;
   localparam int last_bit = beat_width - 1;

   // payload of one beat
   typedef logic [data_width-1:0] data_t;
   // byte-valid flags of one beat
   typedef logic [keep_width-1:0] keep_t;
   // memory word, 37 bits
   typedef logic [beat_width-1:0] beat_t;

endpackage

//--- src/fifo_dual_ram.sv
// fifo_dual_ram: beat storage with write port in aclk and registered read port in clk_out
`timescale 1ns/1ps

module fifo_dual_ram (
   input  logic                aclk,
   input  logic                we,
   input  pkt_fifo_pkg::addr_t waddr,
   input  axis_pkg::beat_t     wdata,
   input  logic                clk_out,
   input  pkt_fifo_pkg::addr_t raddr,
   output axis_pkg::beat_t     rdata
);

   // one word per beat slot
   axis_pkg::beat_t mem [pkt_fifo_pkg::fifo_depth];

   // --------------------------------------------------------------------------
   // write side, aclk
   // --------------------------------------------------------------------------

   always_ff @(posedge aclk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // --------------------------------------------------------------------------
   // read side, clk_out
   // --------------------------------------------------------------------------

   // one cycle read latency, the read stage accounts for it
   always_ff @(posedge clk_out) begin
      rdata <= mem[raddr];
   end

endmodule

//--- src/gray_ptr_sync.sv
// gray_ptr_sync: moves a forward-only pointer into another clock domain through Gray code
`timescale 1ns/1ps

module gray_ptr_sync (
   input  logic               src_clk,
   input  logic               src_rst,
   input  pkt_fifo_pkg::ptr_t src_ptr,
   input  logic               dst_clk,
   input  logic               dst_rst,
   output pkt_fifo_pkg::ptr_t dst_ptr
);

   pkt_fifo_pkg::ptr_t src_bin;
   pkt_fifo_pkg::ptr_t src_step;
   pkt_fifo_pkg::ptr_t src_gray;
   pkt_fifo_pkg::ptr_t sync_meta;
   pkt_fifo_pkg::ptr_t sync_gray;

   // --------------------------------------------------------------------------
   // source domain
   // --------------------------------------------------------------------------

   // walk one count per edge toward the source pointer
   // so the Gray register only ever changes a single bit
   assign src_step = (src_bin != src_ptr) ? src_bin + pkt_fifo_pkg::ptr_t'(1) : src_bin;

   always_ff @(posedge src_clk) begin
      if (src_rst) begin
         src_bin  <= '0;
         src_gray <= '0;
      end else begin
         src_bin  <= src_step;
         src_gray <= src_step ^ (src_step >> 1);
      end
   end

   // --------------------------------------------------------------------------
   // destination domain
   // --------------------------------------------------------------------------

   // two flop synchronizer
   always_ff @(posedge dst_clk) begin
      if (dst_rst) begin
         sync_meta <= '0;
         sync_gray <= '0;
      end else begin
         sync_meta <= src_gray;
         sync_gray <= sync_meta;
      end
   end

   // Gray to binary, msb passes straight through
   always_comb begin
      dst_ptr[pkt_fifo_pkg::addr_width] = sync_gray[pkt_fifo_pkg::addr_width];
      for (int i = pkt_fifo_pkg::addr_width - 1; i >= 0; i--) begin
         dst_ptr[i] = dst_ptr[i+1] ^ sync_gray[i];
      end
   end

endmodule

//--- src/pkt_fifo_async.sv
// pkt_fifo_async: packet-aware dual-clock stream FIFO with whole-packet drop on error or overflow
`timescale 1ns/1ps

module pkt_fifo_async (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    in_tvalid,
   input  axis_pkg::data_t         in_tdata,
   input  axis_pkg::keep_t         in_tkeep,
   input  logic                    in_tlast,
   input  logic                    in_tuser,
   input  logic                    clk_out,
   input  logic                    out_tready,
   output logic                    out_tvalid,
   output axis_pkg::data_t         out_tdata,
   output axis_pkg::keep_t         out_tkeep,
   output logic                    out_tlast,
   output pkt_fifo_pkg::drop_cnt_t drop_count
);

   axis_if in_beat ();
   axis_if out_beat ();

   logic                we;
   pkt_fifo_pkg::addr_t waddr;
   axis_pkg::beat_t     wdata;
   pkt_fifo_pkg::addr_t raddr;
   axis_pkg::beat_t     rdata;
   pkt_fifo_pkg::ptr_t  commit_ptr;
   pkt_fifo_pkg::ptr_t  commit_ptr_sync;
   pkt_fifo_pkg::ptr_t  rd_ptr;
   pkt_fifo_pkg::ptr_t  rd_ptr_sync;
   logic                rst_out;

   // --------------------------------------------------------------------------
   // port mapping
   // --------------------------------------------------------------------------

   // input cannot be stalled
   assign in_beat.tvalid  = in_tvalid;
   assign in_beat.tdata   = in_tdata;
   assign in_beat.tkeep   = in_tkeep;
   assign in_beat.tlast   = in_tlast;
   assign in_beat.tuser   = in_tuser;
   assign in_beat.tready  = 1'b1;

   assign out_beat.tready = out_tready;
   assign out_tvalid      = out_beat.tvalid;
   assign out_tdata       = out_beat.tdata;
   assign out_tkeep       = out_beat.tkeep;
   assign out_tlast       = out_beat.tlast;

   // --------------------------------------------------------------------------
   // write domain
   // --------------------------------------------------------------------------

   pkt_wr_ctrl u_pkt_wr_ctrl (
      .aclk        (aclk),
      .rst         (rst),
      .in_beat     (in_beat),
      .rd_ptr_sync (rd_ptr_sync),
      .we          (we),
      .waddr       (waddr),
      .wdata       (wdata),
      .commit_ptr  (commit_ptr),
      .drop_count  (drop_count)
   );

   fifo_dual_ram u_fifo_dual_ram (
      .aclk    (aclk),
      .we      (we),
      .waddr   (waddr),
      .wdata   (wdata),
      .clk_out (clk_out),
      .raddr   (raddr),
      .rdata   (rdata)
   );

   // committed boundary toward the reader
   gray_ptr_sync u_commit_sync (
      .src_clk (aclk),
      .src_rst (rst),
      .src_ptr (commit_ptr),
      .dst_clk (clk_out),
      .dst_rst (rst_out),
      .dst_ptr (commit_ptr_sync)
   );

   // freed slots back toward the writer
   gray_ptr_sync u_rd_ptr_sync (
      .src_clk (clk_out),
      .src_rst (rst_out),
      .src_ptr (rd_ptr),
      .dst_clk (aclk),
      .dst_rst (rst),
      .dst_ptr (rd_ptr_sync)
   );

   // --------------------------------------------------------------------------
   // read domain
   // --------------------------------------------------------------------------

   pkt_rd_side u_pkt_rd_side (
      .clk_out         (clk_out),
      .rst             (rst),
      .commit_ptr_sync (commit_ptr_sync),
      .raddr           (raddr),
      .rdata           (rdata),
      .rd_ptr          (rd_ptr),
      .rst_out         (rst_out),
      .out_beat        (out_beat)
   );

endmodule

//--- src/pkt_fifo_pkg.sv
// pkt_fifo_pkg: buffer depth, address, pointer and drop counter types of the packet FIFO
package pkt_fifo_pkg;

   // --------------------------------------------------------------------------
   // buffer geometry
   // --------------------------------------------------------------------------

   // number of beat slots in the buffer
   localparam int fifo_depth = 16;
   // address bits to index every slot
   localparam int addr_width = $clog2(fifo_depth);
   // width of the drop counter, wraps on overflow
   localparam int drop_width = 16;

   // memory address
   typedef logic [addr_width-1:0] addr_t;

   // pointer with one extra wrap bit above the address
   // equal pointers mean empty, a difference of fifo_depth means full
   typedef logic [addr_width:0] ptr_t;

   // count of packets thrown away
   typedef logic [drop_width-1:0] drop_cnt_t;

endpackage

//--- src/pkt_rd_side.sv
// pkt_rd_side: read-domain reset sync, read pointer, empty test and fall-through output stage
`timescale 1ns/1ps

module pkt_rd_side (
   input  logic                clk_out,
   input  logic                rst,
   input  pkt_fifo_pkg::ptr_t  commit_ptr_sync,
   output pkt_fifo_pkg::addr_t raddr,
   input  axis_pkg::beat_t     rdata,
   output pkt_fifo_pkg::ptr_t  rd_ptr,
   output logic                rst_out,
   axis_if.tx                  out_beat
);

   logic            rst_meta;
   logic            empty;
   logic            rd_en;
   logic            rd_pend;
   logic            pop;
   logic [1:0]      occ;
   logic            out_valid;
   logic            skid_valid;
   axis_pkg::beat_t out_data;
   axis_pkg::beat_t skid_data;

   // --------------------------------------------------------------------------
   // reset into clk_out
   // --------------------------------------------------------------------------

   always_ff @(posedge clk_out) begin
      rst_meta <= rst;
      rst_out  <= rst_meta;
   end

   // --------------------------------------------------------------------------
   // read issue
   // --------------------------------------------------------------------------

   // only committed beats are visible
   assign empty = (rd_ptr == commit_ptr_sync);
   assign raddr = rd_ptr[pkt_fifo_pkg::addr_width-1:0];
   assign pop   = out_valid && out_beat.tready;

   // beats held or in flight, output register plus skid plus pending read
   assign occ   = {1'b0, out_valid} + {1'b0, skid_valid} + {1'b0, rd_pend};
   // never have more in flight than the two holding registers can take
   assign rd_en = !empty && ((occ - {1'b0, pop}) < 2'd2);

   // --------------------------------------------------------------------------
   // output stage control
   // --------------------------------------------------------------------------

   always_ff @(posedge clk_out) begin
      if (rst_out) begin
         rd_ptr     <= '0;
         rd_pend    <= 1'b0;
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         // slot is free once its read is issued, rdata already holds it
         if (rd_en) begin
            rd_ptr <= rd_ptr + pkt_fifo_pkg::ptr_t'(1);
         end
         rd_pend <= rd_en;
         if (!out_valid || pop) begin
            // skid first to keep order
            out_valid  <= skid_valid || rd_pend;
            skid_valid <= skid_valid && rd_pend;
         end else if (rd_pend) begin
            // output held under back-pressure, park the new beat
            skid_valid <= 1'b1;
         end
      end
   end

   // payload moves with the control above
   always_ff @(posedge clk_out) begin
      if (!out_valid || pop) begin
         if (skid_valid) begin
            out_data <= skid_data;
            skid_data <= rdata;
         end else begin
            out_data <= rdata;
         end
      end else if (rd_pend) begin
         skid_data <= rdata;
      end
   end

   // --------------------------------------------------------------------------
   // stream output
   // --------------------------------------------------------------------------

   assign out_beat.tvalid = out_valid;
   assign out_beat.tdata  = out_data[axis_pkg::data_width-1:0];
   assign out_beat.tkeep  = out_data[axis_pkg::keep_lsb +: axis_pkg::keep_width];
   assign out_beat.tlast  = out_data[axis_pkg::last_bit];
   // errored packets never commit
   assign out_beat.tuser  = 1'b0;

endmodule

//--- src/pkt_wr_ctrl.sv
// pkt_wr_ctrl: write-side packet control with commit, rewind on error or overflow, drop count
`timescale 1ns/1ps

module pkt_wr_ctrl (
   input  logic                    aclk,
   input  logic                    rst,
   axis_if.rx                      in_beat,
   input  pkt_fifo_pkg::ptr_t      rd_ptr_sync,
   output logic                    we,
   output pkt_fifo_pkg::addr_t     waddr,
   output axis_pkg::beat_t         wdata,
   output pkt_fifo_pkg::ptr_t      commit_ptr,
   output pkt_fifo_pkg::drop_cnt_t drop_count
);

   // packet boundary tracking
   typedef enum logic [1:0] {
      st_idle,
      st_in_pkt,
      st_discard
   } wr_state_t;

   wr_state_t          state;
   pkt_fifo_pkg::ptr_t wr_ptr;
   pkt_fifo_pkg::ptr_t wr_ptr_inc;
   logic               full;
   logic               accept;
   logic               overflow;
   logic               bad_last;
   logic               drop;

   // --------------------------------------------------------------------------
   // beat qualification
   // --------------------------------------------------------------------------

   assign wr_ptr_inc = wr_ptr + pkt_fifo_pkg::ptr_t'(1);

   // read pointer lags the real one, so full is pessimistic and never wrong
   assign full = (wr_ptr - rd_ptr_sync) == pkt_fifo_pkg::ptr_t'(pkt_fifo_pkg::fifo_depth);

   // a strobe with no room kills the whole packet
   assign overflow = in_beat.tvalid && (state != st_discard) && full;
   // a strobe that lands in memory
   assign accept   = in_beat.tvalid && (state != st_discard) && !full;
   // last beat flagged bad, the packet goes away
   assign bad_last = accept && in_beat.tlast && in_beat.tuser;

   assign drop = overflow || bad_last;

   // --------------------------------------------------------------------------
   // memory write port
   // --------------------------------------------------------------------------

   // write on the strobe edge itself
   assign we    = accept;
   assign waddr = wr_ptr[pkt_fifo_pkg::addr_width-1:0];
   // stored word is {last, keep, data}
   assign wdata = {in_beat.tlast, in_beat.tkeep, in_beat.tdata};

   // --------------------------------------------------------------------------
   // pointers and drop counter
   // --------------------------------------------------------------------------

   always_ff @(posedge aclk) begin
      if (rst) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         drop_count <= '0;
      end else if (drop) begin
         // rewind to the last committed boundary
         wr_ptr     <= commit_ptr;
         drop_count <= drop_count + pkt_fifo_pkg::drop_cnt_t'(1);
      end else if (accept) begin
         wr_ptr <= wr_ptr_inc;
         // a good last beat makes the packet visible to the reader
         if (in_beat.tlast) begin
            commit_ptr <= wr_ptr_inc;
         end
      end
   end

   // --------------------------------------------------------------------------
   // packet state
   // --------------------------------------------------------------------------

   always_ff @(posedge aclk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle, st_in_pkt: begin
               if (in_beat.tvalid) begin
                  if (in_beat.tlast) begin
                     // packet ends here, good, bad or overflowed
                     state <= st_idle;
                  end else if (overflow) begin
                     // swallow the rest of this packet
                     state <= st_discard;
                  end else begin
                     state <= st_in_pkt;
                  end
               end
            end
            st_discard: begin
               // last beat of the dropped packet is still ignored
               if (in_beat.tvalid && in_beat.tlast) begin
                  state <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

//--- tb.f
src/axis_pkg.sv
src/pkt_fifo_pkg.sv
src/axis_if.sv
src/pkt_wr_ctrl.sv
src/fifo_dual_ram.sv
src/gray_ptr_sync.sv
src/pkt_rd_side.sv
src/pkt_fifo_async.sv
testbench/tb_pkt_fifo_async.sv

//--- testbench/pkt_stimulus.txt
# columns: test_id length err_flag data_base(hex) last_keep(hex) ready_mode
# ready_mode: 0 ready high, 1 random ready with idle gaps, 2 ready held low
# test 1: good packets of every length, ready high
1 1 0 10000000 1 0
1 2 0 10000100 3 0
1 3 0 10000200 7 0
1 4 0 10000300 f 0
1 5 0 10000400 1 0
1 6 0 10000500 3 0
1 7 0 10000600 7 0
1 8 0 10000700 f 0
1 9 0 10000800 1 0
1 10 0 10000900 3 0
1 11 0 10000a00 7 0
1 12 0 10000b00 f 0
1 13 0 10000c00 1 0
1 14 0 10000d00 3 0
1 15 0 10000e00 7 0
1 16 0 10000f00 f 0
# test 2: errored packets between good ones
2 5 0 20000000 f 0
2 6 1 20000100 f 0
2 3 0 20000200 7 0
2 1 1 20000300 1 0
2 16 1 20000400 f 0
2 7 0 20000500 3 0
# test 3: fill with ready low, overflow drops, then recovery
3 8 0 30000000 f 2
3 8 0 30000100 7 2
3 3 0 30000200 f 2
3 9 0 30000300 f 2
3 4 0 30000400 3 0
3 20 0 30000500 f 0
3 17 0 30000600 1 0
3 6 0 30000700 f 0
# test 4: random back-pressure and idle gaps
4 12 0 40000000 f 1
4 1 0 40000100 1 1
4 7 0 40000200 3 1
4 16 0 40000300 f 1
4 5 1 40000400 f 1
4 9 0 40000500 7 1
4 3 1 40000600 1 1
4 14 0 40000700 f 1
# test 5: second fill after random traffic
5 10 0 50000000 f 2
5 6 0 50000100 7 2
5 2 1 50000200 3 2
5 4 0 50000300 f 2
5 8 0 50000400 1 1

//--- testbench/tb_pkt_fifo_async.sv
// tb_pkt_fifo_async: file-driven testbench for the packet FIFO with a queue reference model
`timescale 1ns/1ps

module tb_pkt_fifo_async;

   localparam int depth = pkt_fifo_pkg::fifo_depth;
   // beats the output stage can pull out of the buffer while tready is low
   localparam int out_stage_beats = 2;
   // aclk cycles for both pointer synchronizers to catch up
   localparam int settle_cycles = 6;

   logic                    aclk;
   logic                    clk_out;
   logic                    rst;
   logic                    in_tvalid;
   axis_pkg::data_t         in_tdata;
   axis_pkg::keep_t         in_tkeep;
   logic                    in_tlast;
   logic                    in_tuser;
   logic                    out_tready;
   logic                    out_tvalid;
   axis_pkg::data_t         out_tdata;
   axis_pkg::keep_t         out_tkeep;
   logic                    out_tlast;
   pkt_fifo_pkg::drop_cnt_t drop_count;

   int seed = 32'h9191;
   // 0 ready high, 1 random ready, 2 ready low
   int ready_mode = 0;
   int limit_ns = 0;
   // good packets whose last input beat has been driven
   int pkts_closed = 0;

   // stimulus table, one entry per file line
   int          s_len[$];
   int          s_err[$];
   int          s_mode[$];
   logic [31:0] s_base[$];
   logic [31:0] s_keep[$];

   // expected output beats in order, with their good-packet number
   axis_pkg::data_t q_data[$];
   axis_pkg::keep_t q_keep[$];
   logic            q_last[$];
   int              q_pkt[$];

   pkt_fifo_async u_pkt_fifo_async (
      .aclk       (aclk),
      .rst        (rst),
      .in_tvalid  (in_tvalid),
      .in_tdata   (in_tdata),
      .in_tkeep   (in_tkeep),
      .in_tlast   (in_tlast),
      .in_tuser   (in_tuser),
      .clk_out    (clk_out),
      .out_tready (out_tready),
      .out_tvalid (out_tvalid),
      .out_tdata  (out_tdata),
      .out_tkeep  (out_tkeep),
      .out_tlast  (out_tlast),
      .drop_count (drop_count)
   );

   // --------------------------------------------------------------------------
   // clocks
   // --------------------------------------------------------------------------

   initial begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   // unrelated read clock, edges never line up with aclk
   initial begin
      clk_out = 1'b0;
      forever #6.5 clk_out = ~clk_out;
   end

   // --------------------------------------------------------------------------
   // reporting and compare tasks
   // --------------------------------------------------------------------------

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_beat(
      input axis_pkg::data_t got_data,
      input axis_pkg::keep_t got_keep,
      input logic            got_last,
      input axis_pkg::data_t exp_data,
      input axis_pkg::keep_t exp_keep,
      input logic            exp_last
   );
      if (got_data !== exp_data || got_keep !== exp_keep || got_last !== exp_last) begin
         abort_run($sformatf("mismatch at %0t: data %h keep %h last %0b, expected %h %h %0b",
                             $time, got_data, got_keep, got_last,
                             exp_data, exp_keep, exp_last));
      end
   endtask

   task automatic check_drops(input pkt_fifo_pkg::drop_cnt_t got,
                              input pkt_fifo_pkg::drop_cnt_t exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: drop_count %0d, expected %0d", $time, got, exp));
      end
   endtask

   // --------------------------------------------------------------------------
   // stimulus file and packet driver
   // --------------------------------------------------------------------------

   task automatic load_stimulus(output int total_beats);
      int          fd;
      int          rc;
      string       line;
      int          id, len, err, mode;
      logic [31:0] base, keep;
      total_beats = 0;
      fd = $fopen("testbench/pkt_stimulus.txt", "r");
      if (fd == 0) begin
         abort_run("could not open testbench/pkt_stimulus.txt");
      end
      while (!$feof(fd)) begin
         rc = $fgets(line, fd);
         // blank lines and # comments carry no packet
         if (rc > 1 && line.substr(0, 0) != "#") begin
            rc = $sscanf(line, "%d %d %d %h %h %d", id, len, err, base, keep, mode);
            if (rc != 6 || len < 1 || mode < 0 || mode > 2) begin
               abort_run({"malformed stimulus line: ", line});
            end
            s_len.push_back(len);
            s_err.push_back(err);
            s_base.push_back(base);
            s_keep.push_back(keep);
            s_mode.push_back(mode);
            total_beats += len;
         end
      end
      $fclose(fd);
   endtask

   // payload rule: base plus beat index, full keep except on the last beat
   task automatic push_expected(input int len, input logic [31:0] base,
                                input logic [31:0] last_keep, input int pkt_no);
      for (int i = 0; i < len; i++) begin
         q_data.push_back(axis_pkg::data_t'(base + 32'(i)));
         q_keep.push_back((i == len - 1) ? axis_pkg::keep_t'(last_keep) : '1);
         q_last.push_back(i == len - 1);
         q_pkt.push_back(pkt_no);
      end
   endtask

   task automatic send_packet(input int len, input int err, input logic [31:0] base,
                              input logic [31:0] last_keep, input logic gaps);
      logic [31:0] rnd;
      int          idle;
      for (int i = 0; i < len; i++) begin
         if (gaps) begin
            rnd  = $random(seed);
            idle = int'(rnd[1:0]);
            repeat (idle) begin
               @(posedge aclk);
               #1;
               in_tvalid = 1'b0;
            end
         end
         @(posedge aclk);
         #1;
         in_tvalid = 1'b1;
         in_tdata  = axis_pkg::data_t'(base + 32'(i));
         in_tkeep  = (i == len - 1) ? axis_pkg::keep_t'(last_keep) : '1;
         in_tlast  = (i == len - 1);
         // error flag only counts on the last beat
         in_tuser  = (err != 0) && (i == len - 1);
      end
      @(posedge aclk);
      #1;
      in_tvalid = 1'b0;
      in_tlast  = 1'b0;
      in_tuser  = 1'b0;
   endtask

   // --------------------------------------------------------------------------
   // main sequence
   // --------------------------------------------------------------------------

   initial begin
      int total_beats;
      int pending;
      int good;
      int exp_drops;
      int good_pkts;
      int prev_mode;
      rst       = 1'b1;
      in_tvalid = 1'b0;
      in_tdata  = '0;
      in_tkeep  = '0;
      in_tlast  = 1'b0;
      in_tuser  = 1'b0;
      exp_drops = 0;
      good_pkts = 0;
      prev_mode = 0;
      $timeformat(-9, 1, " ns", 10);
      load_stimulus(total_beats);
      // 40 ns per beat plus drain and settle time per packet
      limit_ns = total_beats * 40 + s_len.size() * 200 + 2000;
      repeat (2) @(posedge aclk);
      #1;
      rst = 1'b0;
      // read-side reset sync needs a few clk_out edges
      repeat (4) @(posedge clk_out);

      for (int n = 0; n < s_len.size(); n++) begin
         if (s_mode[n] == 2) begin
            if (prev_mode != 2) begin
               // fill test starts from an empty buffer
               ready_mode = 0;
               while (q_data.size() != 0) @(posedge aclk);
               ready_mode = 2;
            end
         end else begin
            ready_mode = s_mode[n];
            if (s_err[n] == 0 && s_len[n] > depth) begin
               while (q_data.size() != 0) @(posedge aclk);
            end else if (s_err[n] == 0) begin
               while (q_data.size() + s_len[n] > depth) @(posedge aclk);
            end
         end
         repeat (settle_cycles) @(posedge aclk);
         pending = q_data.size();

         // reference decision for this packet
         if (s_err[n] != 0 || s_len[n] > depth) begin
            good = 0;
         end else if (s_mode[n] != 2 || pending + s_len[n] <= depth) begin
            good = 1;
         end else if (pending + s_len[n] > depth + out_stage_beats) begin
            good = 0;
         end else begin
            abort_run("stimulus line leaves the fill test undecided");
         end

         if (good != 0) begin
            push_expected(s_len[n], s_base[n], s_keep[n], good_pkts);
         end else begin
            exp_drops++;
         end
         send_packet(s_len[n], s_err[n], s_base[n], s_keep[n], s_mode[n] == 1);
         if (good != 0) begin
            good_pkts++;
            pkts_closed = good_pkts;
         end
         prev_mode = s_mode[n];
      end

      ready_mode = 0;
      while (q_data.size() != 0) @(posedge aclk);
      // idle stretch to catch any stray beat
      repeat (40) @(posedge clk_out);
      check_drops(drop_count, pkt_fifo_pkg::drop_cnt_t'(exp_drops));
      $display("All tests passed");
      $finish;
   end

   // --------------------------------------------------------------------------
   // output ready, monitor and watchdog
   // --------------------------------------------------------------------------

   initial begin
      logic [31:0] rnd;
      out_tready = 1'b0;
      forever begin
         @(posedge clk_out);
         #1;
         case (ready_mode)
            1: begin
               rnd        = $random(seed);
               out_tready = rnd[0];
            end
            2: out_tready = 1'b0;
            default: out_tready = 1'b1;
         endcase
      end
   end

   // sampled at negedge, half a cycle away from every output change
   initial begin
      logic            held_valid;
      axis_pkg::data_t held_data;
      axis_pkg::keep_t held_keep;
      logic            held_last;
      held_valid = 1'b0;
      held_data  = '0;
      held_keep  = '0;
      held_last  = 1'b0;
      @(negedge rst);
      repeat (4) @(posedge clk_out);
      forever begin
         @(negedge clk_out);
         // a beat not taken must stay put
         if (held_valid) begin
            if (out_tvalid !== 1'b1) begin
               abort_run("output tvalid fell before its beat was accepted");
            end
            check_beat(out_tdata, out_tkeep, out_tlast, held_data, held_keep, held_last);
         end
         if (out_tvalid && out_tready) begin
            if (q_data.size() == 0) begin
               abort_run("output beat arrived while no packet was expected");
            end
            if (q_pkt[0] >= pkts_closed) begin
               abort_run("output beat arrived before its packet's last input beat");
            end
            check_beat(out_tdata, out_tkeep, out_tlast, q_data[0], q_keep[0], q_last[0]);
            void'(q_data.pop_front());
            void'(q_keep.pop_front());
            void'(q_last.pop_front());
            void'(q_pkt.pop_front());
            held_valid = 1'b0;
         end else begin
            held_valid = out_tvalid;
            held_data  = out_tdata;
            held_keep  = out_tkeep;
            held_last  = out_tlast;
         end
      end
   end

   initial begin
      wait (limit_ns > 0);
      #(limit_ns);
      abort_run($sformatf("timeout: run did not finish within %0d ns", limit_ns));
   end

endmodule
